//--- common/irq_params.svh
// IRQ subsystem constants: implemented line mask, CSR addresses and status bit positions
`ifndef IRQ_PARAMS_SVH
`define IRQ_PARAMS_SVH

// Implemented lines: custom 31..16, MEI 11, MTI 7, MSI 3
`define IRQ_MASK          32'hFFFF_0888

// Machine CSR addresses
`define CSR_MSTATUS       12'h300
`define CSR_MIE           12'h304
`define CSR_MCAUSE        12'h342
`define CSR_MIP           12'h344

// mstatus field positions
`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7
`define MSTATUS_MPP_LSB   11   // Two bits wide

// Standard interrupt ids
`define IRQ_MEI_BIT       11   // External
`define IRQ_MSI_BIT       3    // Software
`define IRQ_MTI_BIT       7    // Timer
`endif

//--- common/irq_pkg.sv
// IRQ subsystem package: privilege, CSR operation and trap FSM state types
`default_nettype none

package irq_pkg;

  ////////////////////////////////////////////////////////////
  // Privilege levels
  ////////////////////////////////////////////////////////////

  // Only machine and user exist, encodings as in mstatus.MPP
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  ////////////////////////////////////////////////////////////
  // Host CSR access
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_READ  = 2'b00,   // No side effect
    CSR_WRITE = 2'b01,   // Full replace
    CSR_SET   = 2'b10,   // OR in wdata
    CSR_CLEAR = 2'b11    // AND out wdata
  } csr_op_e;

  ////////////////////////////////////////////////////////////
  // Trap controller FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    TS_RUN   = 1'b0,     // Executing, traps allowed
    TS_SLEEP = 1'b1      // Parked in wfi
  } trap_state_e;

endpackage

`default_nettype wire

//--- common/trap_if.sv
// Trap interface: trap entry, mret and enable state between trap controller and CSR block
`timescale 1ns/1ps
`default_nettype none

interface trap_if;

  // From trap controller, no handshake
  logic       take;          // One-cycle trap entry strobe
  logic [4:0] take_id;       // Id of the line being taken
  logic       mret;          // One-cycle return strobe

  // From CSR block
  logic       global_ie;     // MIE, or running in user mode
  logic       mstatus_mie;   // Raw mstatus.MIE

  // Trap controller view
  modport ctrl (
    output take, take_id, mret
  );

  // CSR block view
  modport csr (
    input  take, take_id, mret,
    output global_ie, mstatus_mie
  );

endinterface

`default_nettype wire

//--- csr/csr_regs.sv
// Machine CSR block: mstatus, mie, mcause and privilege with host access and trap updates
`timescale 1ns/1ps
`default_nettype none
`include "irq_params.svh"

module csr_regs import irq_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Host access, read data is same-cycle
  input  logic        csr_en_i,
  input  csr_op_e     csr_op_i,
  input  logic [11:0] csr_addr_i,
  input  logic [31:0] csr_wdata_i,
  output logic [31:0] csr_rdata_o,

  // To/from interrupt controller
  input  logic [31:0] mip_i,          // Registered lines, read-only here
  output logic [31:0] mie_bypass_o,   // mie with pending host write merged in

  output priv_lvl_e   priv_lvl_o,
  trap_if.csr         trap
);

  // mstatus fields
  logic        mstatus_mie_q;
  logic        mstatus_mpie_q;
  priv_lvl_e   mstatus_mpp_q;
  priv_lvl_e   priv_q;                // Current privilege

  logic [31:0] mie_q;
  logic        mcause_irq_q;          // Interrupt flag, bit 31
  logic [4:0]  mcause_code_q;

  logic [31:0] mstatus_rd;
  logic [31:0] mcause_rd;
  logic [31:0] csr_old;               // Addressed register before the access
  logic [31:0] csr_new;               // Value after applying the op
  logic        wr_en;
  logic        wr_mstatus;
  logic        wr_mie;
  logic        wr_mcause;
  priv_lvl_e   wr_mpp;

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  // Assemble mstatus, unimplemented bits read zero
  always_comb begin
    mstatus_rd                            = '0;
    mstatus_rd[`MSTATUS_MIE_BIT]          = mstatus_mie_q;
    mstatus_rd[`MSTATUS_MPIE_BIT]         = mstatus_mpie_q;
    mstatus_rd[`MSTATUS_MPP_LSB +: 2]     = mstatus_mpp_q;
  end

  assign mcause_rd = {mcause_irq_q, 26'b0, mcause_code_q};

  always_comb begin
    case (csr_addr_i)
      `CSR_MSTATUS: csr_old = mstatus_rd;
      `CSR_MIE:     csr_old = mie_q;
      `CSR_MIP:     csr_old = mip_i;
      `CSR_MCAUSE:  csr_old = mcause_rd;
      default:      csr_old = '0;       // Unknown address
    endcase
  end

  assign csr_rdata_o = csr_old;       // Old value, same cycle

  ////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (csr_op_i)
      CSR_WRITE: csr_new = csr_wdata_i;
      CSR_SET:   csr_new = csr_old | csr_wdata_i;
      CSR_CLEAR: csr_new = csr_old & ~csr_wdata_i;
      default:   csr_new = csr_old;
    endcase
  end

  assign wr_en      = csr_en_i && (csr_op_i != CSR_READ);
  assign wr_mstatus = wr_en && (csr_addr_i == `CSR_MSTATUS);
  assign wr_mie     = wr_en && (csr_addr_i == `CSR_MIE);
  assign wr_mcause  = wr_en && (csr_addr_i == `CSR_MCAUSE);   // mip writes fall through

  // MPP holds only legal levels, anything nonzero maps to M
  assign wr_mpp = (csr_new[`MSTATUS_MPP_LSB +: 2] == 2'b00) ? PRIV_U : PRIV_M;

  // Interrupt controller sees the new mie in the write cycle
  assign mie_bypass_o = wr_mie ? (csr_new & `IRQ_MASK) : mie_q;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mie_q <= '0;
    end else begin
      mie_q <= mie_bypass_o;
    end
  end

  // Trap entry and mret override a host write to mstatus
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mstatus_mpp_q  <= PRIV_M;
      priv_q         <= PRIV_M;
    end else if (trap.take) begin
      mstatus_mpie_q <= mstatus_mie_q;  // Stack enable
      mstatus_mie_q  <= 1'b0;
      mstatus_mpp_q  <= priv_q;         // Stack privilege
      priv_q         <= PRIV_M;
    end else if (trap.mret) begin
      mstatus_mie_q  <= mstatus_mpie_q; // Unstack
      mstatus_mpie_q <= 1'b1;
      priv_q         <= mstatus_mpp_q;
      mstatus_mpp_q  <= PRIV_U;
    end else if (wr_mstatus) begin
      mstatus_mie_q  <= csr_new[`MSTATUS_MIE_BIT];
      mstatus_mpie_q <= csr_new[`MSTATUS_MPIE_BIT];
      mstatus_mpp_q  <= wr_mpp;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mcause_irq_q  <= 1'b0;
      mcause_code_q <= '0;
    end else if (trap.take) begin
      mcause_irq_q  <= 1'b1;            // Always an interrupt here
      mcause_code_q <= trap.take_id;
    end else if (wr_mcause) begin
      mcause_irq_q  <= csr_new[31];
      mcause_code_q <= csr_new[4:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Status out
  ////////////////////////////////////////////////////////////

  assign trap.mstatus_mie = mstatus_mie_q;
  assign trap.global_ie   = trap.mstatus_mie || (priv_q == PRIV_U);  // User mode always open
  assign priv_lvl_o       = priv_q;

endmodule

`default_nettype wire

//--- int_controller/int_controller.sv
// Interrupt controller: registers masked lines, qualifies them and picks the winning id
`timescale 1ns/1ps
`default_nettype none
`include "irq_params.svh"

module int_controller (
  input  logic        clk,
  input  logic        rst_n,

  input  logic [31:0] irq_i,          // Level lines, asynchronous to nothing here

  // To/from CSR block
  input  logic [31:0] mie_bypass_i,
  input  logic        global_ie_i,
  output logic [31:0] mip_o,

  // To trap controller
  output logic        irq_req_o,
  output logic [4:0]  irq_id_o,
  output logic        irq_wu_o
);

  logic [31:0] irq_q;
  logic [31:0] irq_qual;              // Registered and locally enabled

  ////////////////////////////////////////////////////////////
  // Line capture
  ////////////////////////////////////////////////////////////

  // Reserved lines never reach the register
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_i & `IRQ_MASK;
    end
  end

  assign mip_o    = irq_q;
  assign irq_qual = irq_q & mie_bypass_i;

  // Request needs a local and the global enable
  assign irq_req_o = (|irq_qual) && global_ie_i;

  // Wake-up looks at the raw lines
  // mie is already masked, so reserved lines cannot wake
  assign irq_wu_o = |(irq_i & mie_bypass_i);

  ////////////////////////////////////////////////////////////
  // Priority encoder
  ////////////////////////////////////////////////////////////

  // Lowest priority first, later hits overwrite earlier ones
  // Order top down: 31..16, MEI, MSI, MTI
  always_comb begin
    irq_id_o = 5'(`IRQ_MTI_BIT);      // Default, also when idle
    if (irq_qual[`IRQ_MSI_BIT]) begin
      irq_id_o = 5'(`IRQ_MSI_BIT);
    end
    if (irq_qual[`IRQ_MEI_BIT]) begin
      irq_id_o = 5'(`IRQ_MEI_BIT);
    end
    for (int i = 16; i < 32; i++) begin
      if (irq_qual[i]) begin
        irq_id_o = 5'(i);             // Custom lines, highest index wins
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/irq_subsys_top.sv
// Interrupt subsystem top: CSR block, interrupt controller and trap controller
`timescale 1ns/1ps
`default_nettype none

module irq_subsys_top import irq_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  logic [31:0] irq_i,

  // Host CSR port
  input  logic        csr_en_i,
  input  csr_op_e     csr_op_i,
  input  logic [11:0] csr_addr_i,
  input  logic [31:0] csr_wdata_i,
  output logic [31:0] csr_rdata_o,

  // Core events
  input  logic        mret_i,
  input  logic        wfi_i,

  output logic        trap_o,
  output logic [4:0]  trap_id_o,
  output logic        sleep_o,
  output priv_lvl_e   priv_lvl_o
);

  logic [31:0] mie_bypass;
  logic [31:0] mip;
  logic        irq_req;
  logic [4:0]  irq_id;
  logic        irq_wu;

  trap_if trap_bus ();                // CSR block <-> trap controller

  ////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////

  csr_regs u_csr (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_en_i     (csr_en_i),
    .csr_op_i     (csr_op_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .mip_i        (mip),
    .mie_bypass_o (mie_bypass),
    .priv_lvl_o   (priv_lvl_o),
    .trap         (trap_bus.csr)
  );

  int_controller u_intc (
    .clk          (clk),
    .rst_n        (rst_n),
    .irq_i        (irq_i),
    .mie_bypass_i (mie_bypass),
    .global_ie_i  (trap_bus.global_ie),  // Enable straight from the CSR side
    .mip_o        (mip),
    .irq_req_o    (irq_req),
    .irq_id_o     (irq_id),
    .irq_wu_o     (irq_wu)
  );

  trap_ctrl u_trap (
    .clk          (clk),
    .rst_n        (rst_n),
    .irq_req_i    (irq_req),
    .irq_id_i     (irq_id),
    .irq_wu_i     (irq_wu),
    .mret_i       (mret_i),
    .wfi_i        (wfi_i),
    .trap         (trap_bus.ctrl),
    .trap_o       (trap_o),
    .trap_id_o    (trap_id_o),
    .sleep_o      (sleep_o)
  );

endmodule

`default_nettype wire

//--- logic/trap_ctrl.sv
// Trap controller: turns requests into trap pulses, forwards mret, runs the wfi sleep FSM
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl import irq_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // From interrupt controller
  input  logic       irq_req_i,       // Already globally qualified
  input  logic [4:0] irq_id_i,
  input  logic       irq_wu_i,

  // Core events
  input  logic       mret_i,
  input  logic       wfi_i,

  trap_if.ctrl       trap,

  output logic       trap_o,
  output logic [4:0] trap_id_o,
  output logic       sleep_o
);

  trap_state_e state_q;
  trap_state_e state_d;
  logic        running;
  logic        take;

  assign running = (state_q == TS_RUN);

  ////////////////////////////////////////////////////////////
  // Trap and mret strobes
  ////////////////////////////////////////////////////////////

  // mret wins a tie, the line stays pending and is taken later
  assign take = running && irq_req_i && !mret_i;

  // CSR block acts on these at the closing edge
  assign trap.take    = take;
  assign trap.take_id = irq_id_i;
  assign trap.mret    = running && mret_i;   // Ignored while asleep

  ////////////////////////////////////////////////////////////
  // Sleep FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      TS_RUN: begin
        if (wfi_i && !irq_req_i) begin
          state_d = TS_SLEEP;         // Nothing to take, park
        end
      end
      TS_SLEEP: begin
        // Wake on any mie-enabled line, MIE not involved
        if (irq_wu_i) begin
          state_d = TS_RUN;
        end
      end
      default: state_d = TS_RUN;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= TS_RUN;
      sleep_o <= 1'b0;
    end else begin
      state_q <= state_d;
      sleep_o <= (state_d == TS_SLEEP);  // Registered, tracks next state
    end
  end

  ////////////////////////////////////////////////////////////
  // Trap output
  ////////////////////////////////////////////////////////////

  // One-cycle pulse, id held until the next trap
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      trap_o    <= 1'b0;
      trap_id_o <= '0;
    end else begin
      trap_o <= take;
      if (take) begin
        trap_id_o <= irq_id_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/irq_pkg.sv
common/trap_if.sv
csr/csr_regs.sv
int_controller/int_controller.sv
logic/trap_ctrl.sv
logic/irq_subsys_top.sv
tb/irq_subsys_tb.sv

//--- tb/irq_subsys_tb.sv
// Self-checking testbench that drives a stimulus table through the interrupt subsystem
`timescale 1ns/1ps
`default_nettype none
`include "irq_params.svh"

module irq_subsys_tb import irq_pkg::*; ();

  localparam int ROW_MAX = 64;
  localparam int WINDOW  = 4;                 // Cycles spent on each row

  // Row operations
  localparam int OP_CSR  = 0;
  localparam int OP_IRQ  = 1;
  localparam int OP_MRET = 2;
  localparam int OP_WFI  = 3;
  localparam int OP_IDLE = 4;
  localparam int OP_RAND = 5;                 // Random lines plus MIE set in one cycle

  // Expected readback fields
  localparam logic [31:0] MS_MIE   = 32'h1 << `MSTATUS_MIE_BIT;
  localparam logic [31:0] MS_MPIE  = 32'h1 << `MSTATUS_MPIE_BIT;
  localparam logic [31:0] MS_MPP_M = 32'h3 << `MSTATUS_MPP_LSB;
  localparam logic [31:0] MC_IRQ   = 32'h8000_0000;   // mcause interrupt flag

  logic        clk;
  logic        rst_n;
  logic [31:0] irq_i;
  logic        csr_en_i;
  csr_op_e     csr_op_i;
  logic [11:0] csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic        mret_i;
  logic        wfi_i;
  logic        trap_o;
  logic [4:0]  trap_id_o;
  logic        sleep_o;
  priv_lvl_e   priv_lvl_o;

  // Stimulus and expectation table
  int          row_op    [ROW_MAX];
  csr_op_e     row_cop   [ROW_MAX];
  logic [11:0] row_addr  [ROW_MAX];
  logic [31:0] row_wdata [ROW_MAX];
  logic [31:0] row_irq   [ROW_MAX];
  bit          row_chk   [ROW_MAX];           // Compare read data
  logic [31:0] row_rd    [ROW_MAX];
  int          row_at    [ROW_MAX];           // Negedge index of the trap pulse or 0 for none
  logic [4:0]  row_id    [ROW_MAX];
  bit          row_sleep [ROW_MAX];
  priv_lvl_e   row_priv  [ROW_MAX];

  int          n_rows      = 0;
  int          cur_row     = -1;
  int          errors      = 0;
  int          checks      = 0;
  int          cycles      = 0;
  int          cycle_limit = 1000000;         // Replaced once the table is built

  irq_subsys_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_i       (irq_i),
    .csr_en_i    (csr_en_i),
    .csr_op_i    (csr_op_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .mret_i      (mret_i),
    .wfi_i       (wfi_i),
    .trap_o      (trap_o),
    .trap_id_o   (trap_id_o),
    .sleep_o     (sleep_o),
    .priv_lvl_o  (priv_lvl_o)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;                      // 40 ns period

  ////////////////////////////////////////////////////////////
  // Run limit
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Checks: %0d, mismatches: %0d, timeouts: 1", checks, errors);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] want);
    $display("Mismatch at %0t: row %0d, %s, got %0h, expected %0h",
             $time, cur_row, what, got, want);
    errors++;
  endtask

  // Winner among pending lines in the order 31..16 then MEI then MSI then MTI
  function automatic logic [4:0] expected_id(logic [31:0] lines);
    logic [4:0] id;
    bit         found;
    id    = 5'(`IRQ_MTI_BIT);
    found = 1'b0;
    for (int i = 31; i >= 16; i--) begin
      if (!found && lines[i]) begin
        id    = 5'(i);
        found = 1'b1;
      end
    end
    if (!found && lines[`IRQ_MEI_BIT]) begin
      id    = 5'(`IRQ_MEI_BIT);
      found = 1'b1;
    end
    if (!found && lines[`IRQ_MSI_BIT]) begin
      id = 5'(`IRQ_MSI_BIT);
    end
    return id;
  endfunction

  task automatic add_row(int op, csr_op_e cop, logic [11:0] addr, logic [31:0] wdata,
                         logic [31:0] irq, bit chk, logic [31:0] rd, int at,
                         logic [4:0] id, bit slp, priv_lvl_e prv);
    row_op[n_rows]    = op;
    row_cop[n_rows]   = cop;
    row_addr[n_rows]  = addr;
    row_wdata[n_rows] = wdata;
    row_irq[n_rows]   = irq;
    row_chk[n_rows]   = chk;
    row_rd[n_rows]    = rd;
    row_at[n_rows]    = at;
    row_id[n_rows]    = id;
    row_sleep[n_rows] = slp;
    row_priv[n_rows]  = prv;
    n_rows++;
  endtask

  task automatic build_table();
    // Masking, mip and mie readback
    add_row(OP_IRQ,  CSR_READ,  `CSR_MIP, '0, 32'hFFFF_FFFF, 1, `IRQ_MASK, 0, '0, 0, PRIV_M);
    add_row(OP_CSR,  CSR_READ,  `CSR_MIP, '0, '0, 1, `IRQ_MASK, 0, '0, 0, PRIV_M);
    add_row(OP_CSR,  CSR_WRITE, `CSR_MIE, 32'hFFFF_FFFF, '0, 1, '0, 0, '0, 0, PRIV_M);
    add_row(OP_CSR,  CSR_READ,  `CSR_MIE, '0, '0, 1, `IRQ_MASK, 0, '0, 0, PRIV_M);
    add_row(OP_IRQ,  CSR_READ,  '0, '0, '0, 0, '0, 0, '0, 0, PRIV_M);
    add_row(OP_CSR,  CSR_READ,  12'h7C0, '0, '0, 1, '0, 0, '0, 0, PRIV_M);  // Unknown CSR
    // Trap entry with the line held off while MIE is clear
    add_row(OP_IRQ,  CSR_READ,  '0, '0, 32'h1 << `IRQ_MEI_BIT, 0, '0, 0, '0, 0, PRIV_M);
    add_row(OP_CSR,  CSR_SET,   `CSR_MSTATUS, MS_MIE, '0, 1, MS_MPP_M, 3, 5'd11, 0, PRIV_M);
    add_row(OP_CSR,  CSR_READ,  `CSR_MCAUSE, '0, '0, 1, MC_IRQ | 32'd11, 0, '0, 0, PRIV_M);
    add_row(OP_CSR,  CSR_READ,  `CSR_MSTATUS, '0, '0, 1, MS_MPP_M | MS_MPIE, 0, '0, 0, PRIV_M);
    // mret re-enables and the pending line traps again
    add_row(OP_MRET, CSR_READ,  '0, '0, '0, 0, '0, 3, 5'd11, 0, PRIV_M);
    add_row(OP_CSR,  CSR_READ,  `CSR_MSTATUS, '0, '0, 1, MS_MPP_M | MS_MPIE, 0, '0, 0, PRIV_M);
    // Return to user mode where traps are taken with MIE clear
    add_row(OP_CSR,  CSR_WRITE, `CSR_MSTATUS, '0, '0, 1, MS_MPP_M | MS_MPIE, 0, '0, 0, PRIV_M);
    add_row(OP_IRQ,  CSR_READ,  '0, '0, '0, 0, '0, 0, '0, 0, PRIV_M);
    add_row(OP_MRET, CSR_READ,  '0, '0, '0, 0, '0, 0, '0, 0, PRIV_U);
    add_row(OP_CSR,  CSR_READ,  `CSR_MSTATUS, '0, '0, 1, MS_MPIE, 0, '0, 0, PRIV_U);
    add_row(OP_IRQ,  CSR_READ,  '0, '0, 32'h1 << `IRQ_MTI_BIT, 0, '0, 3, 5'd7, 0, PRIV_M);
    add_row(OP_CSR,  CSR_READ,  `CSR_MCAUSE, '0, '0, 1, MC_IRQ | 32'd7, 0, '0, 0, PRIV_M);
    add_row(OP_CSR,  CSR_READ,  `CSR_MSTATUS, '0, '0, 1, '0, 0, '0, 0, PRIV_M);
    // Priority checks with random lines and MIE set in the same cycle
    for (int i = 0; i < 8; i++) begin
      add_row(OP_RAND, CSR_SET, `CSR_MSTATUS, MS_MIE, '0, 0, '0, 3, '0, 0, PRIV_M);
    end
    // wfi sleep and wake-up from mie-enabled lines only
    add_row(OP_IRQ,  CSR_READ,  '0, '0, '0, 0, '0, 0, '0, 0, PRIV_M);
    add_row(OP_CSR,  CSR_WRITE, `CSR_MIE, 32'h1 << `IRQ_MTI_BIT, '0, 1, `IRQ_MASK, 0, '0, 0,
            PRIV_M);
    add_row(OP_WFI,  CSR_READ,  '0, '0, '0, 0, '0, 0, '0, 1, PRIV_M);
    add_row(OP_IRQ,  CSR_READ,  '0, '0, 32'h1 << `IRQ_MEI_BIT, 0, '0, 0, '0, 1, PRIV_M);
    add_row(OP_IRQ,  CSR_READ,  '0, '0, 32'h0000_0880, 0, '0, 0, '0, 0, PRIV_M);
    add_row(OP_IDLE, CSR_READ,  '0, '0, '0, 0, '0, 0, '0, 0, PRIV_M);
  endtask

  ////////////////////////////////////////////////////////////
  // Row driver that starts and ends on a rising edge
  ////////////////////////////////////////////////////////////

  task automatic apply_row(int r);
    int          pulses;
    int          first_at;
    int          want_pulses;
    int          read_at;
    logic [4:0]  got_id;
    logic [4:0]  want_id;
    logic [31:0] pat;
    logic        got_sleep;
    priv_lvl_e   got_priv;
    cur_row  = r;
    pulses   = 0;
    first_at = 0;
    got_id   = '0;
    want_id  = row_id[r];
    pat      = row_irq[r];
    read_at  = (row_op[r] == OP_IRQ) ? 2 : 1;  // New lines reach mip one edge later
    if (row_op[r] == OP_RAND) begin
      pat = $urandom & `IRQ_MASK;
      if ($urandom % 2) begin
        pat = pat & 32'h0000_0FFF;            // Standard lines only
      end
      if (pat == '0) begin
        pat = 32'h1 << `IRQ_MSI_BIT;
      end
      want_id = expected_id(pat);
    end
    csr_en_i    <= (row_op[r] == OP_CSR) || (row_op[r] == OP_RAND);
    csr_op_i    <= row_cop[r];
    csr_addr_i  <= row_addr[r];
    csr_wdata_i <= row_wdata[r];
    mret_i      <= (row_op[r] == OP_MRET);
    wfi_i       <= (row_op[r] == OP_WFI);
    if ((row_op[r] == OP_IRQ) || (row_op[r] == OP_RAND)) begin
      irq_i <= pat;                           // Lines hold until the next irq row
    end
    for (int k = 1; k <= WINDOW; k++) begin
      @(negedge clk);
      if ((k == read_at) && row_chk[r]) begin
        checks++;
        assert (csr_rdata_o == row_rd[r])
          else report_mismatch("csr read data", csr_rdata_o, row_rd[r]);
      end
      if (trap_o) begin
        pulses++;
        if (first_at == 0) begin
          first_at = k;
          got_id   = trap_id_o;
        end
      end
      got_sleep = sleep_o;
      got_priv  = priv_lvl_o;
      @(posedge clk);
      if (k == 1) begin
        csr_en_i <= 1'b0;                     // Single-cycle strobes
        mret_i   <= 1'b0;
        wfi_i    <= 1'b0;
      end
    end
    want_pulses = (row_at[r] != 0) ? 1 : 0;
    checks += 3;
    assert (pulses == want_pulses) else report_mismatch("trap pulses", pulses, want_pulses);
    assert (got_sleep == row_sleep[r]) else report_mismatch("sleep", got_sleep, row_sleep[r]);
    assert (got_priv == row_priv[r]) else report_mismatch("privilege", got_priv, row_priv[r]);
    if ((want_pulses == 1) && (pulses > 0)) begin
      checks += 2;
      assert (first_at == row_at[r]) else report_mismatch("trap cycle", first_at, row_at[r]);
      assert (got_id == want_id) else report_mismatch("trap id", got_id, want_id);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n       = 1'b0;
    irq_i       = '0;
    csr_en_i    = 1'b0;
    csr_op_i    = CSR_READ;
    csr_addr_i  = '0;
    csr_wdata_i = '0;
    mret_i      = 1'b0;
    wfi_i       = 1'b0;
    void'($urandom(72474));                   // Seed once
    build_table();
    cycle_limit = n_rows * 8 + 50;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    checks += 3;
    assert (trap_o == 1'b0) else report_mismatch("trap after reset", trap_o, 0);
    assert (sleep_o == 1'b0) else report_mismatch("sleep after reset", sleep_o, 0);
    assert (priv_lvl_o == PRIV_M)
      else report_mismatch("privilege after reset", priv_lvl_o, PRIV_M);
    @(posedge clk);
    for (int r = 0; r < n_rows; r++) begin
      apply_row(r);
    end
    $display("Checks: %0d, mismatches: %0d, timeouts: 0", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
